// ==== vlog.f ====
+incdir+.
scene_pkg.sv
flash_if.sv
uart_rx.sv
scene_loader.sv
cam_regs.sv
obj_mem.sv
scene_upload_top.sv
tb_scene_upload.sv

// ==== tb_scene_upload.sv ====
`timescale 1ns/1ps
`include "scene_consts.svh"

module tb_scene_upload;

  logic                  clk;
  logic                  rst;
  logic                  uart_rxd;
  scene_pkg::cam_sel_e   cam_sel;
  scene_pkg::vec3_t      cam_vec;
  logic [`OBJ_IDX_W-1:0] obj_rd_idx;
  scene_pkg::object_t    obj_rd_data;
  logic                  upload_busy;
  logic                  upload_done;

  // Reference model of the camera registers and the object memory.
  scene_pkg::vec3_t   cam_model [4];
  scene_pkg::object_t obj_model [`NUM_OBJS];
  bit                 obj_written [`NUM_OBJS];

  logic [7:0]  payload [`OBJ_BYTES];  // Data bytes of the current command.
  bit          cmd_sent;              // Set once the command byte is on the line.
  int          done_count;            // upload_done pulses seen.
  int          expected_dones;
  int unsigned seed_val;

  scene_upload_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .uart_rxd    (uart_rxd),
    .cam_sel     (cam_sel),
    .cam_vec     (cam_vec),
    .obj_rd_idx  (obj_rd_idx),
    .obj_rd_data (obj_rd_data),
    .upload_busy (upload_busy),
    .upload_done (upload_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && upload_done) begin
      done_count++;
    end
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_cam(input string name, input scene_pkg::vec3_t exp,
                           input scene_pkg::vec3_t act);
    if (act !== exp) begin
      fail_stop($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_obj(input string name, input scene_pkg::object_t exp,
                           input scene_pkg::object_t act);
    if (act !== exp) begin
      fail_stop($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_stop($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  // First data byte ends up in the lowest bits.
  function automatic logic [103:0] pack_bytes(input int n);
    logic [103:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = payload[i];
    end
    return v;
  endfunction

  task automatic drive_bit(input logic v);
    @(posedge clk);
    #1;
    uart_rxd = v;
    repeat (`CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // One UART frame after a random idle gap.
  task automatic send_byte(input logic [7:0] b, input bit bad_stop);
    repeat ($urandom_range(2, 17)) @(posedge clk);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(!bad_stop);
    if (bad_stop) begin
      @(posedge clk);
      #1;
      uart_rxd = 1'b1;  // Back to idle.
    end
  endtask

  task automatic send_upload(input logic [7:0] cmd, input int n, input int bad_at);
    send_byte(cmd, 1'b0);
    cmd_sent = 1'b1;
    for (int i = 0; i < n; i++) begin
      if (i == bad_at) begin
        send_byte(8'($urandom_range(0, 255)), 1'b1);  // Framing error, dropped.
      end
      send_byte(payload[i], 1'b0);
    end
  endtask

  task automatic watch_upload(input int nbytes);
    int limit;
    int cnt;
    limit = nbytes * 12 * `CLKS_PER_BIT;
    cnt = 0;
    while (!cmd_sent) begin
      @(negedge clk);
      cnt++;
      if (cnt > limit) fail_stop("command byte was never sent");
    end
    @(negedge clk);
    while (!upload_done) begin
      check_bit("upload_busy", 1'b1, upload_busy);
      @(negedge clk);
      cnt++;
      if (cnt > limit) fail_stop("upload_done never asserted");
    end
    check_bit("upload_busy", 1'b1, upload_busy);
    @(negedge clk);
    check_bit("upload_done", 1'b0, upload_done);  // Single-cycle strobe.
    check_bit("upload_busy", 1'b0, upload_busy);
  endtask

  task automatic do_upload(input logic [7:0] cmd, input int n, input int bad_at);
    int nbytes;
    nbytes = 1 + n + ((bad_at >= 0) ? 1 : 0);
    @(negedge clk);
    check_bit("upload_busy", 1'b0, upload_busy);
    cmd_sent = 1'b0;
    fork
      send_upload(cmd, n, bad_at);
      watch_upload(nbytes);
    join
    expected_dones++;
    check_count("upload_done pulses", expected_dones, done_count);
  endtask

  task automatic read_all_cam();
    for (int s = 0; s < 4; s++) begin
      @(posedge clk);
      #1;
      cam_sel = scene_pkg::cam_sel_e'(s);
      @(negedge clk);
      check_cam($sformatf("cam_vec[%0d]", s), cam_model[s], cam_vec);
    end
  endtask

  task automatic read_obj(input int idx);
    @(posedge clk);
    #1;
    obj_rd_idx = idx[`OBJ_IDX_W-1:0];
    @(posedge clk);  // One cycle read latency.
    @(negedge clk);
    check_obj($sformatf("obj_rd_data[%0d]", idx), obj_model[idx], obj_rd_data);
  endtask

  task automatic cam_upload(input int bad_at, input bit readback);
    logic [1:0]   sel;
    logic [7:0]   cmd;
    logic [103:0] flat;
    sel = 2'($urandom_range(0, 3));
    cmd = {1'b1, 5'($urandom_range(0, 31)), sel};
    for (int i = 0; i < `CAM_BYTES; i++) begin
      payload[i] = 8'($urandom_range(0, 255));
    end
    do_upload(cmd, `CAM_BYTES, bad_at);
    flat = pack_bytes(`CAM_BYTES);
    cam_model[sel] = flat[`CAM_BYTES*8-1:0];
    if (readback) read_all_cam();
  endtask

  task automatic obj_upload(input int bad_at, input bit readback);
    logic [`OBJ_IDX_W-1:0] idx;
    logic [7:0]            cmd;
    idx = `OBJ_IDX_W'($urandom_range(0, `NUM_OBJS - 1));
    cmd = {1'b0, 3'($urandom_range(0, 7)), idx};  // Upper bits must not move the address.
    for (int i = 0; i < `OBJ_BYTES; i++) begin
      payload[i] = 8'($urandom_range(0, 255));
    end
    do_upload(cmd, `OBJ_BYTES, bad_at);
    obj_model[idx] = pack_bytes(`OBJ_BYTES);
    obj_written[idx] = 1'b1;
    if (readback) read_obj(idx);
  endtask

  initial begin
    rst = 1'b1;
    uart_rxd = 1'b1;
    cam_sel = scene_pkg::CAM_ORIGIN;
    obj_rd_idx = '0;
    cmd_sent = 1'b0;
    done_count = 0;
    expected_dones = 0;
    seed_val = $urandom(61);
    for (int i = 0; i < 4; i++) begin
      cam_model[i] = '0;
    end
    for (int i = 0; i < `NUM_OBJS; i++) begin
      obj_written[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset values.
    @(negedge clk);
    check_bit("upload_busy", 1'b0, upload_busy);
    read_all_cam();

    repeat (8) cam_upload(-1, 1'b1);
    repeat (8) obj_upload(-1, 1'b1);

    // A bad frame inside a command, then one extra good byte.
    cam_upload($urandom_range(0, `CAM_BYTES - 1), 1'b1);
    obj_upload($urandom_range(0, `OBJ_BYTES - 1), 1'b1);

    // Mixed traffic with a full readback at the end.
    for (int i = 0; i < 40; i++) begin
      if ($urandom_range(0, 1) == 1) begin
        cam_upload(-1, 1'b0);
      end else begin
        obj_upload(-1, 1'b0);
      end
    end
    read_all_cam();
    for (int i = 0; i < `NUM_OBJS; i++) begin
      if (obj_written[i]) read_obj(i);
    end
    check_count("upload_done pulses", expected_dones, done_count);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== scene_upload_top.sv ====
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_upload_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  uart_rxd,
  input  scene_pkg::cam_sel_e   cam_sel,
  output scene_pkg::vec3_t      cam_vec,
  input  logic [`OBJ_IDX_W-1:0] obj_rd_idx,
  output scene_pkg::object_t    obj_rd_data,
  output logic                  upload_busy,
  output logic                  upload_done
);

  logic       rx_valid;
  logic [7:0] rx_byte;

  flash_if flash ();

  uart_rx u_rx (
    .clk      (clk),
    .rst      (rst),
    .rxd      (uart_rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  scene_loader u_loader (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .flash    (flash.loader)
  );

  cam_regs u_cam (
    .clk     (clk),
    .rst     (rst),
    .flash   (flash.store),
    .cam_sel (cam_sel),
    .cam_vec (cam_vec)
  );

  obj_mem u_obj (
    .clk         (clk),
    .flash       (flash.store),
    .obj_rd_idx  (obj_rd_idx),
    .obj_rd_data (obj_rd_data)
  );

  // Upload status for the host side.
  assign upload_busy = flash.active;
  assign upload_done = flash.wen;

endmodule

// ==== obj_mem.sv ====
`timescale 1ns/1ps
`include "scene_consts.svh"

module obj_mem (
  input  logic                  clk,
  flash_if.store                flash,
  input  logic [`OBJ_IDX_W-1:0] obj_rd_idx,
  output scene_pkg::object_t    obj_rd_data
);

  scene_pkg::object_t mem [`NUM_OBJS];

  logic                  obj_wen;
  logic [`OBJ_IDX_W-1:0] wr_idx;

  assign obj_wen = flash.wen && !flash.cmd[7];
  assign wr_idx  = flash.cmd[`OBJ_IDX_W-1:0];  // Upper command bits ignored.

  always_ff @(posedge clk) begin
    if (obj_wen) begin
      mem[wr_idx] <= flash.obj_data;
    end
    obj_rd_data <= mem[obj_rd_idx];  // Read before write on a collision.
  end

endmodule

// ==== cam_regs.sv ====
`timescale 1ns/1ps

module cam_regs (
  input  logic                clk,
  input  logic                rst,
  flash_if.store              flash,
  input  scene_pkg::cam_sel_e cam_sel,
  output scene_pkg::vec3_t    cam_vec
);

  // Origin, right, forward and up, indexed by cam_sel_e.
  scene_pkg::vec3_t cam_q [4];

  logic cam_wen;

  assign cam_wen = flash.wen && flash.cmd[7];  // Camera commands only.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        cam_q[i] <= '0;
      end
    end else if (cam_wen) begin
      cam_q[flash.cmd[1:0]] <= flash.cam_data;
    end
  end

  // Renderer read port, no latency.
  assign cam_vec = cam_q[cam_sel];

endmodule

// ==== scene_loader.sv ====
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_loader (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_valid,
  input  logic [7:0] rx_byte,
  flash_if.loader    flash
);

  localparam int CAM_W = `CAM_BYTES * 8;
  localparam int OBJ_W = `OBJ_BYTES * 8;
  localparam int CNT_W = $clog2(`OBJ_BYTES);

  scene_pkg::loader_state_e state;
  logic [CNT_W-1:0]         byte_cnt;
  logic                     last_byte;

  // Final data byte of the current command.
  always_comb begin
    case (state)
      scene_pkg::LD_CAM: last_byte = (byte_cnt == CNT_W'(`CAM_BYTES - 1));
      scene_pkg::LD_OBJ: last_byte = (byte_cnt == CNT_W'(`OBJ_BYTES - 1));
      default:           last_byte = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= scene_pkg::LD_IDLE;
      byte_cnt     <= '0;
      flash.active <= 1'b0;
      flash.wen    <= 1'b0;
    end else begin
      flash.wen <= 1'b0;
      case (state)
        scene_pkg::LD_IDLE: begin
          byte_cnt     <= '0;
          flash.active <= rx_valid;  // Drops one cycle after wen.
          if (rx_valid) begin
            if (rx_byte[7]) begin
              state <= scene_pkg::LD_CAM;
            end else begin
              state <= scene_pkg::LD_OBJ;
            end
          end
        end
        scene_pkg::LD_CAM, scene_pkg::LD_OBJ: begin
          if (rx_valid) begin
            if (last_byte) begin
              byte_cnt  <= '0;
              flash.wen <= 1'b1;
              state     <= scene_pkg::LD_IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        default: begin
          state        <= scene_pkg::LD_IDLE;
          flash.active <= 1'b0;
        end
      endcase
    end
  end

  // Payload shifters. Bytes enter at the top so the first one ends lowest.
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        scene_pkg::LD_IDLE: begin
          flash.cmd <= rx_byte;
        end
        scene_pkg::LD_CAM: begin
          flash.cam_data <= {rx_byte, flash.cam_data[CAM_W-1:8]};
        end
        scene_pkg::LD_OBJ: begin
          flash.obj_data <= {rx_byte, flash.obj_data[OBJ_W-1:8]};
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "scene_consts.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_BREAK   // Bad stop bit, wait for the line to return high.
  } rx_state_e;

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`CLKS_PER_BIT - 1);

  rx_state_e        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;  // Idle line level.
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_sync) begin
            state <= RX_START;  // Falling edge, possible start bit.
          end
        end
        RX_START: begin
          if (clk_cnt == HALF_END) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (!rxd_sync) begin
              state <= RX_DATA;  // Now aligned to mid-bit.
            end else begin
              state <= RX_IDLE;  // Glitch, not a start bit.
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt  <= '0;
            rx_valid <= rxd_sync;  // No strobe on a framing error.
            if (rxd_sync) begin
              state <= RX_IDLE;
            end else begin
              state <= RX_BREAK;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_BREAK: begin
          if (rxd_sync) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data shifter, LSB arrives first.
  always_ff @(posedge clk) begin
    if (state == RX_DATA && clk_cnt == BIT_END) begin
      rx_byte <= {rxd_sync, rx_byte[7:1]};
    end
  end

endmodule

// ==== flash_if.sv ====
`timescale 1ns/1ps

// One finished upload, presented to the camera and object stores.
interface flash_if;

  logic                 active;    // Upload in progress.
  logic [7:0]           cmd;       // Command byte of the upload.
  scene_pkg::vec3_t     cam_data;  // Assembled camera vector.
  scene_pkg::object_t   obj_data;  // Assembled scene object.
  logic                 wen;       // One-cycle write strobe.

  modport loader (
    output active,
    output cmd,
    output cam_data,
    output obj_data,
    output wen
  );

  // Stores decode cmd bit 7 themselves.
  modport store (
    input active,
    input cmd,
    input cam_data,
    input obj_data,
    input wen
  );

endinterface

// ==== scene_pkg.sv ====
`include "scene_consts.svh"

package scene_pkg;

  // Three coordinates, x at the top. The first data byte lands in z[7:0].
  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
    logic [`COORD_W-1:0] z;
  } vec3_t;

  // One sphere, 104 bits. Color sits in the lowest bits.
  typedef struct packed {
    vec3_t       center;
    logic [15:0] radius;
    logic [15:0] color;
  } object_t;

  // Camera register select, coded like command bits 1:0.
  typedef enum logic [1:0] {
    CAM_ORIGIN  = 2'd0,
    CAM_RIGHT   = 2'd1,
    CAM_FORWARD = 2'd2,
    CAM_UP      = 2'd3
  } cam_sel_e;

  // Command parser states.
  typedef enum logic [1:0] {
    LD_IDLE,  // Waiting for a command byte.
    LD_CAM,   // Collecting camera vector bytes.
    LD_OBJ    // Collecting object bytes.
  } loader_state_e;

endpackage

// ==== scene_consts.svh ====
`ifndef SCENE_CONSTS_SVH
`define SCENE_CONSTS_SVH

// UART bit time in clock cycles.
`define CLKS_PER_BIT 16

// Object memory depth and index width.
`define NUM_OBJS  16
`define OBJ_IDX_W 4

// Data bytes that follow each command byte.
`define CAM_BYTES 9
`define OBJ_BYTES 13

// Fixed-point coordinate width.
`define COORD_W 24

`endif
